/* files.f */
src/dmem_pkg.sv
src/dmem_pma_regs.sv
src/dmem_access_chk.sv
src/dmem_biu_ctrl.sv
src/dmem_ctrl.sv
tests/tb_biu_mem.sv
tests/tb_dmem_ctrl.sv

/* Bender.yml */
package:
  name: dmem_ctrl

sources:
  # Design
  - files:
      - src/dmem_pkg.sv
      - src/dmem_pma_regs.sv
      - src/dmem_access_chk.sv
      - src/dmem_biu_ctrl.sv
      - src/dmem_ctrl.sv

  # Testbench
  - target: test
    files:
      - tests/tb_biu_mem.sv
      - tests/tb_dmem_ctrl.sv

/* tests/tb_dmem_ctrl.sv */
// Testbench for the data memory access block, random loads and stores against a reference model
`timescale 1ns/100ps

module tb_dmem_ctrl;

  import dmem_pkg::*;

  // Verdict codes of the reference model
  localparam int V_PASS = 0;
  localparam int V_ERR  = 1;
  localparam int V_MIS  = 2;

  // Run limit, 400 requests of at most 16 cycles
  localparam int TIMEOUT_CYCLES = 400 * 16;

  logic                 clk;
  logic                 rst_n;
  logic                 cfg_we;
  logic [PMA_IDX_W-1:0] cfg_idx;
  pma_entry_t           cfg_entry;
  dmem_req_t            mem_req;
  prv_t                 prv;
  dmem_rsp_t            mem_rsp;
  biu_req_t             biu;
  logic                 stb_ack;
  logic                 bus_ack;
  logic                 bus_err;
  logic [XLEN-1:0]      bus_q;
  logic [XLEN-1:0]      err_lo;
  logic [XLEN-1:0]      err_hi;

  // Reference model state
  pma_entry_t           tbl [PMA_CNT];
  logic [XLEN-1:0]      shadow [256];
  int                   errors;
  int                   accesses;
  int                   cycle_cnt;

  //////////////////////////////////////////////////////////////////////
  // DUT and bus model
  //////////////////////////////////////////////////////////////////////

  dmem_ctrl dut (
    .clk_i         ( clk       ),
    .rst_n_i       ( rst_n     ),
    .cfg_we_i      ( cfg_we    ),
    .cfg_idx_i     ( cfg_idx   ),
    .cfg_entry_i   ( cfg_entry ),
    .mem_req_i     ( mem_req   ),
    .prv_i         ( prv       ),
    .mem_rsp_o     ( mem_rsp   ),
    .biu_o         ( biu       ),
    .biu_stb_ack_i ( stb_ack   ),
    .biu_ack_i     ( bus_ack   ),
    .biu_err_i     ( bus_err   ),
    .biu_q_i       ( bus_q     )
  );

  tb_biu_mem u_bus (
    .clk_i     ( clk     ),
    .biu_i     ( biu     ),
    .err_lo_i  ( err_lo  ),
    .err_hi_i  ( err_hi  ),
    .stb_ack_o ( stb_ack ),
    .ack_o     ( bus_ack ),
    .err_o     ( bus_err ),
    .q_o       ( bus_q   )
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Hang guard
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] fill_word(int i);
    logic [7:0] a;
    a = i[7:0];
    return {a, ~a, a ^ 8'h5a, a + 8'h31};
  endfunction

  function automatic logic [3:0] lane_mask(biu_size_t size, logic [1:0] off);
    logic [3:0] base;
    case (size)
      BYTE:    base = 4'b0001;
      HWORD:   base = 4'b0011;
      default: base = 4'b1111;
    endcase
    return base << off;
  endfunction

  // Lowest valid region that hits decides, error before misalignment
  function automatic int expect_verdict(logic we, biu_size_t size, logic [XLEN-1:0] adr);
    int   hit_idx;
    logic mis;
    hit_idx = -1;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      if (hit_idx < 0 && tbl[i].valid && ((adr & tbl[i].mask) == tbl[i].base))
      begin
        hit_idx = i;
      end
    end
    if (hit_idx < 0)
    begin
      return V_ERR;
    end
    if (we ? !tbl[hit_idx].writable : !tbl[hit_idx].readable)
    begin
      return V_ERR;
    end
    mis = (size == HWORD && adr[0]) || (size == WORD && adr[1:0] != 2'b00);
    if (mis && !tbl[hit_idx].allow_misaligned)
    begin
      return V_MIS;
    end
    return V_PASS;
  endfunction

  function automatic pma_entry_t make_region(logic [XLEN-1:0] base, logic rd, logic wr,
                                             logic mis);
    return '{valid: 1'b1, readable: rd, writable: wr, allow_misaligned: mis,
             base: base, mask: 32'hffff_ff00};
  endfunction

  function automatic biu_size_t rand_size();
    return biu_size_t'($urandom_range(2));
  endfunction

  function automatic prv_t rand_prv();
    return $urandom_range(1) ? PRV_M : PRV_U;
  endfunction

  function automatic logic [XLEN-1:0] align_adr(logic [XLEN-1:0] adr, biu_size_t size);
    case (size)
      WORD:    return adr & ~32'h3;
      HWORD:   return adr & ~32'h1;
      default: return adr;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Driving and checking
  //////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    errors++;
  endtask

  task automatic write_region(input int idx, input pma_entry_t entry);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_idx   = idx[PMA_IDX_W-1:0];
    cfg_entry = entry;
    tbl[idx]  = entry;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  // One CPU request held until ack, then compared with the model
  task automatic run_access(input logic we, input biu_size_t size, input logic [XLEN-1:0] adr,
                            input logic [XLEN-1:0] d, input prv_t p);
    int              verdict;
    int              lat;
    int unsigned     stb_before;
    logic            in_win;
    logic            exp_err;
    logic [3:0]      lanes;
    logic [XLEN-1:0] exp_q;
    biu_prot_t       exp_prot;
    verdict    = expect_verdict(we, size, adr);
    in_win     = (adr >= err_lo) && (adr <= err_hi);
    exp_err    = (verdict == V_ERR) || (verdict == V_PASS && in_win);
    exp_q      = (verdict == V_PASS && !in_win && !we) ? shadow[adr[9:2]] : '0;
    exp_prot   = biu_prot_t'({p != PRV_U, 1'b1});
    stb_before = u_bus.stb_cnt;
    @(negedge clk);
    // Gap cycle after the previous ack
    if (mem_rsp.ack)
    begin
      report_error("ack held longer than one cycle");
    end
    mem_req = '{req: 1'b1, we: we, size: size, adr: adr, d: d};
    prv     = p;
    @(negedge clk);
    lat = 1;
    while (!mem_rsp.ack)
    begin
      @(negedge clk);
      lat++;
    end
    accesses++;

    if (mem_rsp.err !== exp_err)
    begin
      report_error($sformatf("adr %h we %0b err %0b, expected %0b", adr, we, mem_rsp.err,
                             exp_err));
    end
    if (mem_rsp.misaligned !== (verdict == V_MIS))
    begin
      report_error($sformatf("adr %h size %0d misaligned %0b, expected %0b", adr, size,
                             mem_rsp.misaligned, verdict == V_MIS));
    end
    if (mem_rsp.q !== exp_q)
    begin
      report_error($sformatf("adr %h q %h, expected %h", adr, mem_rsp.q, exp_q));
    end

    if (verdict != V_PASS)
    begin
      // Checker faults never reach the bus and answer in two cycles
      if (u_bus.stb_cnt != stb_before)
      begin
        report_error($sformatf("adr %h faulted but a bus strobe was seen", adr));
      end
      if (lat != 2)
      begin
        report_error($sformatf("adr %h fault ack after %0d cycles, expected 2", adr, lat));
      end
    end
    else
    begin
      if (u_bus.stb_cnt != stb_before + 1)
      begin
        report_error($sformatf("adr %h passed but %0d strobes were seen", adr,
                               u_bus.stb_cnt - stb_before));
      end
      if (u_bus.last_prot !== exp_prot)
      begin
        report_error($sformatf("adr %h prot %b, expected %b", adr, u_bus.last_prot, exp_prot));
      end
      if (we && !in_win)
      begin
        lanes = lane_mask(size, adr[1:0]);
        for (int b = 0; b < 4; b++)
        begin
          if (lanes[b])
          begin
            shadow[adr[9:2]][8*b +: 8] = d[8*b +: 8];
          end
        end
      end
    end
    mem_req.req = 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int n_acc,
                             input int errs_before);
    $display("Test %0d %-22s %4d accesses, %0d errors", num, name, n_acc,
             errors - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int              e0;
    int              a0;
    biu_size_t       sz;
    logic [XLEN-1:0] adr;
    void'($urandom(32'h5b0d_21a5));
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_idx   = '0;
    cfg_entry = '0;
    mem_req   = '0;
    prv       = PRV_M;
    // Empty error window
    err_lo    = 32'h1;
    err_hi    = 32'h0;
    errors    = 0;
    accesses  = 0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      tbl[i] = '0;
    end
    for (int i = 0; i < 256; i++)
    begin
      shadow[i]    = fill_word(i);
      u_bus.mem[i] = shadow[i];
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // 1) Idle after reset, then every access is an error
    e0 = errors;
    a0 = accesses;
    repeat (20)
    begin
      @(negedge clk);
      if (biu.stb || mem_rsp.ack)
      begin
        report_error("strobe or ack active while idle after reset");
      end
    end
    for (int n = 0; n < 8; n++)
    begin
      sz = rand_size();
      run_access($urandom_range(1), sz, align_adr($urandom_range(32'h3ff), sz), $urandom,
                 rand_prv());
    end
    report_test(1, "reset, empty table", accesses - a0, e0);

    // 2) Region map, then random aligned traffic
    e0 = errors;
    a0 = accesses;
    write_region(0, make_region(32'h0000_0000, 1'b1, 1'b1, 1'b0));
    write_region(1, make_region(32'h0000_0100, 1'b1, 1'b0, 1'b0));
    write_region(2, make_region(32'h0000_0200, 1'b0, 1'b1, 1'b0));
    write_region(3, make_region(32'h0000_0300, 1'b1, 1'b1, 1'b1));
    for (int n = 0; n < 200; n++)
    begin
      sz = rand_size();
      run_access($urandom_range(1), sz, align_adr($urandom_range(32'h3ff), sz), $urandom,
                 rand_prv());
    end
    report_test(2, "random aligned", accesses - a0, e0);

    // 3) Permission and unmapped faults
    e0 = errors;
    a0 = accesses;
    for (int n = 0; n < 10; n++)
    begin
      run_access(1'b1, WORD, 32'h100 | ($urandom_range(63) << 2), $urandom, rand_prv());
      run_access(1'b0, WORD, 32'h200 | ($urandom_range(63) << 2), $urandom, rand_prv());
      run_access($urandom_range(1), WORD, ($urandom | 32'h400) & ~32'h3, $urandom, rand_prv());
    end
    report_test(3, "access faults", accesses - a0, e0);

    // 4) Misaligned halfwords and words over all regions
    e0 = errors;
    a0 = accesses;
    for (int n = 0; n < 60; n++)
    begin
      sz  = $urandom_range(1) ? WORD : HWORD;
      adr = $urandom_range(32'h3ff);
      if (sz == HWORD)
      begin
        adr[0] = 1'b1;
      end
      else if (adr[1:0] == 2'b00)
      begin
        adr[1:0] = 2'($urandom_range(3, 1));
      end
      run_access($urandom_range(1), sz, adr, $urandom, rand_prv());
    end
    report_test(4, "misaligned", accesses - a0, e0);

    // 5) Bus errors, then read back the window
    e0     = errors;
    a0     = accesses;
    err_lo = 32'h0000_0000;
    err_hi = 32'h0000_003f;
    for (int n = 0; n < 16; n++)
    begin
      sz = rand_size();
      run_access($urandom_range(1), sz, align_adr($urandom_range(32'h3f), sz), $urandom,
                 rand_prv());
    end
    err_lo = 32'h1;
    err_hi = 32'h0;
    for (int n = 0; n < 16; n++)
    begin
      run_access(1'b0, WORD, n << 2, '0, rand_prv());
    end
    report_test(5, "bus error window", accesses - a0, e0);

    // 6) Protection follows the privilege level
    e0 = errors;
    a0 = accesses;
    for (int n = 0; n < 40; n++)
    begin
      sz  = rand_size();
      adr = ($urandom_range(1) ? 32'h300 : 32'h000) | $urandom_range(255);
      run_access($urandom_range(1), sz, align_adr(adr, sz), $urandom, rand_prv());
    end
    report_test(6, "protection bits", accesses - a0, e0);

    $display("Summary: 6 tests, %0d accesses, %0d errors", accesses, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* tests/tb_biu_mem.sv */
// BIU memory model with random handshake delays and a selectable bus error window
`timescale 1ns/100ps

module tb_biu_mem (
  input  logic                        clk_i,
  input  dmem_pkg::biu_req_t          biu_i,
  input  logic [dmem_pkg::XLEN-1:0]   err_lo_i,
  input  logic [dmem_pkg::XLEN-1:0]   err_hi_i,
  output logic                        stb_ack_o,
  output logic                        ack_o,
  output logic                        err_o,
  output logic [dmem_pkg::XLEN-1:0]   q_o
);

  import dmem_pkg::*;

  // Word memory, indexed by address bits 9:2
  logic [XLEN-1:0] mem [256];
  int unsigned     stb_cnt;
  biu_prot_t       last_prot;
  biu_req_t        xfer;
  logic [3:0]      lanes;

  initial
  begin
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    err_o     = 1'b0;
    q_o       = '0;
    stb_cnt   = 0;
    last_prot = PROT_INSTR_USER;
    forever
    begin
      @(negedge clk_i);
      if (biu_i.stb)
      begin
        // Address phase, fields captured as the strobe is seen
        xfer      = biu_i;
        stb_cnt++;
        last_prot = xfer.prot;
        repeat ($urandom % 4) @(negedge clk_i);
        stb_ack_o = 1'b1;
        @(negedge clk_i);
        stb_ack_o = 1'b0;

        // Data phase
        repeat ($urandom % 4) @(negedge clk_i);
        // Old word on q even for writes and errors, the DUT must drop it
        q_o = mem[xfer.adr[9:2]];
        if ((xfer.adr >= err_lo_i) && (xfer.adr <= err_hi_i))
        begin
          err_o = 1'b1;
        end
        else
        begin
          case (xfer.size)
            BYTE:    lanes = 4'b0001;
            HWORD:   lanes = 4'b0011;
            default: lanes = 4'b1111;
          endcase
          lanes = lanes << xfer.adr[1:0];
          if (xfer.we)
          begin
            for (int b = 0; b < 4; b++)
            begin
              if (lanes[b])
              begin
                mem[xfer.adr[9:2]][8*b +: 8] = xfer.d[8*b +: 8];
              end
            end
          end
          ack_o = 1'b1;
        end
        @(negedge clk_i);
        ack_o = 1'b0;
        err_o = 1'b0;
        q_o   = '0;
      end
    end
  end

endmodule

/* src/dmem_ctrl.sv */
// Data memory access top joining the PMA registers, the access checker and the BIU controller
`timescale 1ns/100ps

module dmem_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  // PMA configuration
  input  logic                              cfg_we_i,
  input  logic [dmem_pkg::PMA_IDX_W-1:0]    cfg_idx_i,
  input  dmem_pkg::pma_entry_t              cfg_entry_i,

  // CPU side
  input  dmem_pkg::dmem_req_t               mem_req_i,
  input  dmem_pkg::prv_t                    prv_i,
  output dmem_pkg::dmem_rsp_t               mem_rsp_o,

  // BIU side
  output dmem_pkg::biu_req_t                biu_o,
  input  logic                              biu_stb_ack_i,
  input  logic                              biu_ack_i,
  input  logic                              biu_err_i,
  input  logic [dmem_pkg::XLEN-1:0]         biu_q_i
);

  import dmem_pkg::*;

  pma_entry_t pma_tbl [PMA_CNT];
  logic       chk_pass;
  logic       chk_err;
  logic       chk_misaligned;
  biu_prot_t  chk_prot;

  //////////////////////////////////////////////////////////////////////
  // Region table
  //////////////////////////////////////////////////////////////////////

  dmem_pma_regs u_pma_regs (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_idx_i   ( cfg_idx_i   ),
    .cfg_entry_i ( cfg_entry_i ),
    .pma_o       ( pma_tbl     )
  );

  // Combinational verdict on the held request
  dmem_access_chk u_access_chk (
    .req_i        ( mem_req_i      ),
    .prv_i        ( prv_i          ),
    .pma_i        ( pma_tbl        ),
    .pass_o       ( chk_pass       ),
    .err_o        ( chk_err        ),
    .misaligned_o ( chk_misaligned ),
    .prot_o       ( chk_prot       )
  );

  //////////////////////////////////////////////////////////////////////
  // Bus sequencing
  //////////////////////////////////////////////////////////////////////

  dmem_biu_ctrl u_biu_ctrl (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .req_i         ( mem_req_i      ),
    .pass_i        ( chk_pass       ),
    .err_i         ( chk_err        ),
    .misaligned_i  ( chk_misaligned ),
    .prot_i        ( chk_prot       ),
    .mem_rsp_o     ( mem_rsp_o      ),
    .biu_o         ( biu_o          ),
    .biu_stb_ack_i ( biu_stb_ack_i  ),
    .biu_ack_i     ( biu_ack_i      ),
    .biu_err_i     ( biu_err_i      ),
    .biu_q_i       ( biu_q_i        )
  );

endmodule

/* src/dmem_biu_ctrl.sv */
// BIU controller turning checked CPU requests into address and data phase transfers
`timescale 1ns/100ps

module dmem_biu_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // CPU request and checker verdict
  input  dmem_pkg::dmem_req_t         req_i,
  input  logic                        pass_i,
  input  logic                        err_i,
  input  logic                        misaligned_i,
  input  dmem_pkg::biu_prot_t         prot_i,

  // CPU response
  output dmem_pkg::dmem_rsp_t         mem_rsp_o,

  // BIU
  output dmem_pkg::biu_req_t          biu_o,
  input  logic                        biu_stb_ack_i,
  input  logic                        biu_ack_i,
  input  logic                        biu_err_i,
  input  logic [dmem_pkg::XLEN-1:0]   biu_q_i
);

  import dmem_pkg::*;

  biu_state_t state_q, state_d;
  dmem_rsp_t  rsp_q;
  biu_req_t   xfer_q;
  logic       take;
  logic       data_done;
  logic       ack_d;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  // Held request is not taken again in its own ack cycle
  assign take      = (state_q == IDLE) && req_i.req && !rsp_q.ack;
  assign data_done = (state_q == DATA) && (biu_ack_i || biu_err_i);

  // Faults launch the pulse from RESP
  // transfers launch it at data end so RESP is their ack cycle
  assign ack_d = data_done || ((state_q == RESP) && !rsp_q.ack);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE: if (take)          state_d = pass_i ? ADDR : RESP;
      ADDR: if (biu_stb_ack_i) state_d = DATA;
      DATA: if (data_done)     state_d = RESP;
      RESP:                    state_d = IDLE;
      default:                 state_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
      rsp_q   <= '0;
    end
    else
    begin
      state_q   <= state_d;
      rsp_q.ack <= ack_d;

      // Checker fault, no bus cycle
      if (take && !pass_i)
      begin
        rsp_q.err        <= err_i;
        rsp_q.misaligned <= misaligned_i;
        rsp_q.q          <= '0;
      end

      // Bus error beats a simultaneous ack
      if (data_done)
      begin
        rsp_q.err        <= biu_err_i;
        rsp_q.misaligned <= 1'b0;
        rsp_q.q          <= (!biu_err_i && !xfer_q.we) ? biu_q_i : '0;
      end
    end
  end

  // Transfer fields latched once per accepted request
  always_ff @(posedge clk_i)
  begin
    if (take && pass_i)
    begin
      xfer_q <= '{stb: 1'b1, we: req_i.we, size: req_i.size, prot: prot_i,
                  adr: req_i.adr, d: req_i.d};
    end
  end

  assign mem_rsp_o = rsp_q;

  // Strobe comes from the state
  always_comb
  begin
    biu_o     = xfer_q;
    biu_o.stb = (state_q == ADDR);
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Strobe opens only after a passing verdict and never beside a response
  a_stb_addr_only: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    biu_o.stb |-> !mem_rsp_o.ack && ($past(pass_i) || $past(biu_o.stb))
  );

  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_o.ack |=> !mem_rsp_o.ack
  );

  // Address phase fields hold until the strobe is taken
  a_stb_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    biu_o.stb && !biu_stb_ack_i |=> biu_o.stb && $stable(biu_o)
  );

endmodule

/* src/dmem_access_chk.sv */
// Access checker applying misalignment and PMA region rules to a CPU load or store
`timescale 1ns/100ps

module dmem_access_chk (
  // CPU request and privilege
  input  dmem_pkg::dmem_req_t   req_i,
  input  dmem_pkg::prv_t        prv_i,

  // Region table
  input  dmem_pkg::pma_entry_t  pma_i [dmem_pkg::PMA_CNT],

  // Verdict, one-hot while req is high
  output logic                  pass_o,
  output logic                  err_o,
  output logic                  misaligned_o,

  // Protection for the BIU transfer
  output dmem_pkg::biu_prot_t   prot_o
);

  import dmem_pkg::*;

  logic [PMA_CNT-1:0] hit;
  logic               hit_any;
  pma_entry_t         sel;
  logic               adr_misaligned;
  logic               access_err;

  //////////////////////////////////////////////////////////////////////
  // Region lookup
  //////////////////////////////////////////////////////////////////////

  // Per-region address match
  always_comb
  begin
    for (int i = 0; i < PMA_CNT; i++)
    begin
      hit[i] = pma_i[i].valid && ((req_i.adr & pma_i[i].mask) == pma_i[i].base);
    end
  end

  // Walk downwards so the lowest index hit is left in sel
  always_comb
  begin
    hit_any = 1'b0;
    sel     = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--)
    begin
      if (hit[i])
      begin
        hit_any = 1'b1;
        sel     = pma_i[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Rules
  //////////////////////////////////////////////////////////////////////

  // Natural alignment against transfer size
  always_comb
  begin
    case (req_i.size)
      HWORD:   adr_misaligned = req_i.adr[0];
      WORD:    adr_misaligned = |req_i.adr[1:0];
      default: adr_misaligned = 1'b0;
    endcase
  end

  // No region, or direction not permitted
  assign access_err = !hit_any
                    || ( req_i.we && !sel.writable)
                    || (!req_i.we && !sel.readable);

  // Error masks misalignment
  assign err_o        = req_i.req && access_err;
  assign misaligned_o = req_i.req && !access_err && adr_misaligned && !sel.allow_misaligned;

  // Hit region permits the direction and the alignment
  assign pass_o       = req_i.req && hit_any
                     && (req_i.we ? sel.writable : sel.readable)
                     && (!adr_misaligned || sel.allow_misaligned);

  // Always a data access, user only at PRV_U
  assign prot_o = (prv_i == PRV_U) ? PROT_DATA_USER : PROT_DATA_PRIV;

  // Exactly one verdict per request, none when idle
  always_comb
  begin
    a_verdict_onehot: assert #0 (req_i.req ? $onehot({pass_o, err_o, misaligned_o})
                                           : !(pass_o || err_o || misaligned_o));
  end

endmodule

/* src/dmem_pma_regs.sv */
// PMA region table registers, loaded one entry at a time by the configuration strobe
`timescale 1ns/100ps

module dmem_pma_regs (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  // Configuration write port
  input  logic                                cfg_we_i,
  input  logic [dmem_pkg::PMA_IDX_W-1:0]      cfg_idx_i,
  input  dmem_pkg::pma_entry_t                cfg_entry_i,

  // Region table towards the checker
  output dmem_pkg::pma_entry_t                pma_o [dmem_pkg::PMA_CNT]
);

  import dmem_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Table storage
  //////////////////////////////////////////////////////////////////////

  pma_entry_t pma_q [PMA_CNT];

  // All regions invalid out of reset
  // so every access faults until software sets up the map
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < PMA_CNT; i++)
      begin
        pma_q[i] <= '0;
      end
    end
    else if (cfg_we_i)
    begin
      // Single-cycle strobe, no back-pressure
      pma_q[cfg_idx_i] <= cfg_entry_i;
    end
  end

  // Straight from the flops, a write is seen on the next cycle
  assign pma_o = pma_q;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Strobe must always name a real entry
  a_cfg_idx_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_we_i |-> !$isunknown(cfg_idx_i)
  );

endmodule

/* src/dmem_pkg.sv */
// Data memory access package with bus widths, transfer enums and the request structs
package dmem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int XLEN      = 32;

  // PMA region table size
  localparam int PMA_CNT   = 4;
  localparam int PMA_IDX_W = 2;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // BIU transfer size
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } biu_size_t;

  // Bit 0 set for data, bit 1 set for privileged
  typedef enum logic [1:0] {
    PROT_INSTR_USER = 2'b00,
    PROT_DATA_USER  = 2'b01,
    PROT_INSTR_PRIV = 2'b10,
    PROT_DATA_PRIV  = 2'b11
  } biu_prot_t;

  // Privilege levels, only U and M on this core
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_M = 2'b11
  } prv_t;

  // BIU controller states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    ADDR = 2'b01,
    DATA = 2'b10,
    RESP = 2'b11
  } biu_state_t;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // One PMA region, hit when (adr & mask) == base
  typedef struct packed {
    logic            valid;
    logic            readable;
    logic            writable;
    logic            allow_misaligned;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] mask;
  } pma_entry_t;

  // CPU request, held until ack
  typedef struct packed {
    logic            req;
    logic            we;
    biu_size_t       size;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] d;
  } dmem_req_t;

  // CPU response, valid with the ack pulse
  typedef struct packed {
    logic            ack;
    logic            err;
    logic            misaligned;
    logic [XLEN-1:0] q;
  } dmem_rsp_t;

  // BIU address phase request
  typedef struct packed {
    logic            stb;
    logic            we;
    biu_size_t       size;
    biu_prot_t       prot;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] d;
  } biu_req_t;

endpackage
